// File: verilog.f
+incdir+hw
hw/core_pkg.sv
hw/id_ex_if.sv
hw/fetch_unit.sv
hw/decode_control.sv
hw/reg_file.sv
hw/alu_unit.sv
hw/execute_stage.sv
hw/mips_core.sv
testbench/tb_mips_core.sv

// File: testbench/tb_mips_core.sv
`include "core_params.svh"

module tb_mips_core
    import core_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES = 8;
    localparam int DRAIN = 6;
    localparam int IMEM_WORDS = 64;

    logic     clk = 1'b0;
    logic     rst_n;
    logic     imem_stall;
    iaddr_t   imem_addr;
    word_t    imem_rdata;
    logic     wb_valid;
    reg_idx_t wb_reg;
    word_t    wb_data;

    word_t    imem [IMEM_WORDS];
    word_t    prog [$];
    word_t    model_regs [`CORE_REG_COUNT];
    reg_idx_t exp_reg [$];
    word_t    exp_data [$];
    string    cur_test = "none";
    integer   seed = 32'h23f4b160;
    int       cycle_count = 0;
    int       cycle_limit = 0;

    always #4 clk = ~clk;

    mips_core i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .imem_addr  (imem_addr),
        .imem_rdata (imem_rdata),
        .imem_stall (imem_stall),
        .wb_valid   (wb_valid),
        .wb_reg     (wb_reg),
        .wb_data    (wb_data)
    );

    // Unused words hold an unknown opcode tagged with their address
    function automatic word_t fill_word(input iaddr_t a);
        return {6'h3f, a[25:0] ^ 26'(a[29:26])};
    endfunction

    assign imem_rdata = (imem_addr < IMEM_WORDS) ? imem[imem_addr[5:0]] : fill_word(imem_addr);

    task automatic abort_run(input string msg);
        $display("%s: %s", cur_test, msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_word(input string what, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("[FAIL] %s %s: expected %h, actual %h", cur_test, what, exp, act);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_reg(input string what, input reg_idx_t exp, input reg_idx_t act);
        if (act !== exp) begin
            $display("[FAIL] %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_addr(input string what, input iaddr_t exp, input iaddr_t act);
        if (act !== exp) begin
            $display("[FAIL] %s %s: expected %h, actual %h", cur_test, what, exp, act);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[FAIL] %s %s: expected %b, actual %b", cur_test, what, exp, act);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    // Program builders
    task automatic rtype(input funct_t fn, input reg_idx_t rd, input reg_idx_t rs,
                         input reg_idx_t rt);
        prog.push_back({`CORE_OP_RTYPE, rs, rt, rd, 5'd0, fn});
    endtask

    task automatic shift_op(input funct_t fn, input reg_idx_t rd, input reg_idx_t rt,
                            input shamt_t sh);
        prog.push_back({`CORE_OP_RTYPE, 5'd0, rt, rd, sh, fn});
    endtask

    task automatic itype(input opcode_t op, input reg_idx_t rt, input reg_idx_t rs,
                         input imm_t imm);
        prog.push_back({op, rs, rt, imm});
    endtask

    // ISA reference for one instruction
    task automatic model_instr(input word_t ins);
        opcode_t  op;
        funct_t   fn;
        reg_idx_t rs;
        reg_idx_t rt;
        reg_idx_t dest;
        shamt_t   sh;
        imm_t     imm;
        word_t    a;
        word_t    b;
        word_t    sext;
        word_t    res;
        logic     known;
        op = ins[31:26];
        rs = ins[25:21];
        rt = ins[20:16];
        sh = ins[10:6];
        fn = ins[5:0];
        imm = ins[15:0];
        a = model_regs[rs];
        b = model_regs[rt];
        sext = {{16{imm[15]}}, imm};
        known = 1'b1;
        dest = rt;
        res = '0;
        case (op)
            `CORE_OP_RTYPE: begin
                dest = ins[15:11];
                case (fn)
                    `CORE_FN_ADD: res = a + b;
                    `CORE_FN_SUB: res = a - b;
                    `CORE_FN_AND: res = a & b;
                    `CORE_FN_OR:  res = a | b;
                    `CORE_FN_XOR: res = a ^ b;
                    `CORE_FN_NOR: res = ~(a | b);
                    `CORE_FN_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    `CORE_FN_SLL: res = b << sh;
                    `CORE_FN_SRL: res = b >> sh;
                    default:      known = 1'b0;
                endcase
            end
            `CORE_OP_ADDI: res = a + sext;
            `CORE_OP_ANDI: res = a & {16'h0000, imm};
            `CORE_OP_ORI:  res = a | {16'h0000, imm};
            `CORE_OP_SLTI: res = ($signed(a) < $signed(sext)) ? 32'd1 : 32'd0;
            `CORE_OP_LUI:  res = {imm, 16'h0000};
            default:       known = 1'b0;
        endcase
        if (known && dest != 0) begin
            model_regs[dest] = res;
            exp_reg.push_back(dest);
            exp_data.push_back(res);
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst_n <= 1'b0;
        imem_stall <= 1'b0;
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(posedge clk);
            if (i > 0) begin
                check_addr("imem_addr in reset", iaddr_t'(`CORE_RESET_PC >> 2), imem_addr);
                check_flag("wb_valid in reset", 1'b0, wb_valid);
            end
        end
        rst_n <= 1'b1;
    endtask

    task automatic run_program(input bit stall_on);
        iaddr_t exp_addr;
        int     accepted;
        int     len;
        len = prog.size();
        // Reset, program, drain, and a generous stall allowance, doubled
        cycle_limit += 2 * (RESET_CYCLES + 2 + len + DRAIN + (stall_on ? 3 * (len + DRAIN) : 0));
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = (i < len) ? prog[i] : fill_word(iaddr_t'(i));
        end
        for (int i = 0; i < `CORE_REG_COUNT; i++) begin
            model_regs[i] = '0;
        end
        exp_reg.delete();
        exp_data.delete();
        foreach (prog[i]) begin
            model_instr(prog[i]);
        end
        apply_reset();
        exp_addr = iaddr_t'(`CORE_RESET_PC >> 2);
        accepted = 0;
        while (accepted < len + DRAIN) begin
            if (stall_on) begin
                imem_stall <= ($random(seed) & 32'h1) != 0;
            end
            @(posedge clk);
            check_addr("imem_addr", exp_addr, imem_addr);
            if (!imem_stall) begin
                exp_addr++;
                accepted++;
            end
        end
        imem_stall <= 1'b0;
        @(negedge clk);
        if (exp_reg.size() != 0) begin
            abort_run($sformatf("%0d expected results never retired", exp_reg.size()));
        end
    endtask

    // Retirement monitor
    always @(posedge clk) begin
        if (rst_n === 1'b1 && imem_stall === 1'b0 && wb_valid === 1'b1) begin
            if (exp_reg.size() == 0) begin
                abort_run("a result retired that the program should not produce");
            end else begin
                check_reg("wb_reg", exp_reg.pop_front(), wb_reg);
                check_word("wb_data", exp_data.pop_front(), wb_data);
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("Timeout: run went past %0d cycles", cycle_limit);
            $display("TEST FAILED");
            $fatal(1);
        end
    end

    task automatic reset_state();
        cur_test = "reset_state";
        prog.delete();
        run_program(1'b0);
    endtask

    task automatic alu_rtype();
        cur_test = "alu_rtype";
        prog.delete();
        itype(`CORE_OP_ADDI, 1, 0, 16'h1234);
        itype(`CORE_OP_ADDI, 2, 0, imm_t'(-5));
        itype(`CORE_OP_ADDI, 3, 0, 16'd7);
        rtype(`CORE_FN_ADD, 4, 1, 2);
        rtype(`CORE_FN_SUB, 5, 3, 1);
        rtype(`CORE_FN_AND, 6, 1, 2);
        rtype(`CORE_FN_OR, 7, 1, 3);
        rtype(`CORE_FN_XOR, 8, 1, 2);
        rtype(`CORE_FN_NOR, 9, 1, 3);
        // Signed compare both ways round
        rtype(`CORE_FN_SLT, 10, 2, 3);
        rtype(`CORE_FN_SLT, 11, 3, 2);
        shift_op(`CORE_FN_SLL, 12, 2, 5'd4);
        shift_op(`CORE_FN_SRL, 13, 2, 5'd8);
        shift_op(`CORE_FN_SLL, 14, 1, 5'd31);
        run_program(1'b0);
    endtask

    task automatic immediates();
        cur_test = "immediates";
        prog.delete();
        itype(`CORE_OP_ADDI, 1, 0, imm_t'(-1));
        itype(`CORE_OP_ANDI, 2, 1, 16'h8001);
        itype(`CORE_OP_ORI, 3, 0, 16'h8000);
        itype(`CORE_OP_ADDI, 4, 1, imm_t'(-2));
        itype(`CORE_OP_SLTI, 5, 1, imm_t'(-1));
        itype(`CORE_OP_SLTI, 6, 4, imm_t'(-2));
        itype(`CORE_OP_SLTI, 7, 0, imm_t'(-1));
        itype(`CORE_OP_LUI, 8, 0, 16'hbeef);
        itype(`CORE_OP_ORI, 8, 8, 16'h1234);
        run_program(1'b0);
    endtask

    // Back-to-back uses hit forwarding, one apart the register file bypass
    task automatic build_dependency_program();
        prog.delete();
        itype(`CORE_OP_ADDI, 1, 0, 16'd3);
        rtype(`CORE_FN_ADD, 2, 1, 1);
        rtype(`CORE_FN_ADD, 3, 2, 1);
        rtype(`CORE_FN_SUB, 4, 3, 2);
        shift_op(`CORE_FN_SLL, 5, 4, 5'd2);
        rtype(`CORE_FN_OR, 6, 1, 5);
        itype(`CORE_OP_ADDI, 6, 6, 16'd100);
        rtype(`CORE_FN_XOR, 7, 6, 4);
        rtype(`CORE_FN_SLT, 8, 4, 7);
        itype(`CORE_OP_LUI, 9, 0, 16'h8000);
        shift_op(`CORE_FN_SRL, 10, 9, 5'd31);
        rtype(`CORE_FN_ADD, 11, 10, 10);
    endtask

    task automatic dependencies();
        cur_test = "dependencies";
        build_dependency_program();
        run_program(1'b0);
    endtask

    task automatic discarded();
        cur_test = "discarded";
        prog.delete();
        itype(`CORE_OP_ADDI, 0, 0, 16'd5);
        rtype(`CORE_FN_ADD, 5, 0, 0);
        prog.push_back({6'h3f, 26'h0123456});
        rtype(6'h3e, 2, 1, 1);
        itype(`CORE_OP_ADDI, 2, 0, 16'd9);
        rtype(`CORE_FN_ADD, 0, 2, 2);
        rtype(`CORE_FN_ADD, 3, 0, 2);
        rtype(`CORE_FN_OR, 4, 0, 0);
        run_program(1'b0);
    endtask

    task automatic stalled_fetch();
        cur_test = "stalled_fetch";
        build_dependency_program();
        run_program(1'b1);
    endtask

    initial begin
        rst_n = 1'b0;
        imem_stall = 1'b0;
        reset_state();
        alu_rtype();
        immediates();
        dependencies();
        discarded();
        stalled_fetch();
        $display("TEST OK");
        $finish;
    end

endmodule

// File: hw/mips_core.sv
module mips_core
    import core_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    output iaddr_t   imem_addr,
    input  word_t    imem_rdata,
    input  logic     imem_stall,
    output logic     wb_valid,
    output reg_idx_t wb_reg,
    output word_t    wb_data
);

    word_t    instr;
    logic     instr_valid;
    reg_idx_t rs_idx;
    reg_idx_t rt_idx;
    word_t    rs_data;
    word_t    rt_data;

    id_ex_if i_id_ex ();

    fetch_unit i_fetch (
        .clk         (clk),
        .rst_n       (rst_n),
        .imem_stall  (imem_stall),
        .imem_rdata  (imem_rdata),
        .imem_addr   (imem_addr),
        .instr       (instr),
        .instr_valid (instr_valid)
    );

    decode_control i_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .imem_stall  (imem_stall),
        .instr       (instr),
        .instr_valid (instr_valid),
        .rs_idx      (rs_idx),
        .rt_idx      (rt_idx),
        .rs_data     (rs_data),
        .rt_data     (rt_data),
        .id_ex       (i_id_ex.decode)
    );

    // Written straight from EX/WB, no separate writeback register
    reg_file i_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs_idx   (rs_idx),
        .rt_idx   (rt_idx),
        .rs_data  (rs_data),
        .rt_data  (rt_data),
        .wb_valid (wb_valid),
        .wb_reg   (wb_reg),
        .wb_data  (wb_data)
    );

    execute_stage i_execute (
        .clk        (clk),
        .rst_n      (rst_n),
        .imem_stall (imem_stall),
        .id_ex      (i_id_ex.execute),
        .wb_valid   (wb_valid),
        .wb_reg     (wb_reg),
        .wb_data    (wb_data)
    );

endmodule

// File: hw/execute_stage.sv
module execute_stage
    import core_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     imem_stall,
    id_ex_if.execute id_ex,
    output logic     wb_valid,
    output reg_idx_t wb_reg,
    output word_t    wb_data
);

    word_t fwd_rs;
    word_t fwd_rt;
    word_t operand_b;
    word_t alu_result;

    // Result still sitting in EX/WB overrides the stale register read
    assign fwd_rs = (wb_valid && (wb_reg == id_ex.rs)) ? wb_data : id_ex.rs_data;
    assign fwd_rt = (wb_valid && (wb_reg == id_ex.rt)) ? wb_data : id_ex.rt_data;

    assign operand_b = id_ex.use_imm ? id_ex.operand_imm : fwd_rt;

    alu_unit i_alu (
        .op     (id_ex.alu_op),
        .a      (fwd_rs),
        .b      (operand_b),
        .shamt  (id_ex.shamt),
        .result (alu_result)
    );

    // EX/WB valid
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
        end else if (!imem_stall) begin
            wb_valid <= id_ex.valid;
        end
    end

    // EX/WB payload
    always_ff @(posedge clk) begin
        if (!imem_stall) begin
            wb_reg  <= id_ex.dest;
            wb_data <= alu_result;
        end
    end

endmodule

// File: hw/alu_unit.sv
module alu_unit
    import core_pkg::*;
(
    input  alu_op_t op,
    input  word_t   a,
    input  word_t   b,
    input  shamt_t  shamt,
    output word_t   result
);

    always_comb begin
        case (op)
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_XOR: result = a ^ b;
            ALU_NOR: result = ~(a | b);
            // Signed compare, result is 0 or 1
            ALU_SLT: result = word_t'($signed(a) < $signed(b));
            // Shifts act on the rt operand
            ALU_SLL: result = b << shamt;
            ALU_SRL: result = b >> shamt;
            ALU_LUI: result = {b[15:0], 16'h0000};
            default: result = '0;
        endcase
    end

endmodule

// File: hw/reg_file.sv
`include "core_params.svh"

module reg_file
    import core_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  reg_idx_t rs_idx,
    input  reg_idx_t rt_idx,
    output word_t    rs_data,
    output word_t    rt_data,
    input  logic     wb_valid,
    input  reg_idx_t wb_reg,
    input  word_t    wb_data
);

    word_t regs [`CORE_REG_COUNT];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `CORE_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_valid && (wb_reg != '0)) begin
            regs[wb_reg] <= wb_data;
        end
    end

    // $zero first, then a same-cycle write, then the array
    assign rs_data = (rs_idx == '0) ? '0
                   : (wb_valid && (wb_reg == rs_idx)) ? wb_data
                   : regs[rs_idx];
    assign rt_data = (rt_idx == '0) ? '0
                   : (wb_valid && (wb_reg == rt_idx)) ? wb_data
                   : regs[rt_idx];

endmodule

// File: hw/decode_control.sv
`include "core_params.svh"

module decode_control
    import core_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     imem_stall,
    input  word_t    instr,
    input  logic     instr_valid,
    output reg_idx_t rs_idx,
    output reg_idx_t rt_idx,
    input  word_t    rs_data,
    input  word_t    rt_data,
    id_ex_if.decode  id_ex
);

    opcode_t  opcode;
    funct_t   funct;
    shamt_t   shamt;
    imm_t     imm;
    reg_idx_t rd_idx;

    alu_op_t  dec_op;
    logic     dec_use_imm;
    logic     dec_zero_ext;
    logic     dec_known;
    reg_idx_t dec_dest;
    word_t    imm_ext;

    // Instruction fields
    assign opcode = instr[31:26];
    assign rs_idx = instr[25:21];
    assign rt_idx = instr[20:16];
    assign rd_idx = instr[15:11];
    assign shamt  = instr[10:6];
    assign funct  = instr[5:0];
    assign imm    = instr[15:0];

    // Main and ALU control
    always_comb begin
        dec_op       = ALU_ADD;
        dec_use_imm  = 1'b1;
        dec_zero_ext = 1'b0;
        dec_known    = 1'b1;
        dec_dest     = rt_idx;
        case (opcode)
            `CORE_OP_RTYPE: begin
                dec_use_imm = 1'b0;
                dec_dest    = rd_idx;
                case (funct)
                    `CORE_FN_ADD: dec_op = ALU_ADD;
                    `CORE_FN_SUB: dec_op = ALU_SUB;
                    `CORE_FN_AND: dec_op = ALU_AND;
                    `CORE_FN_OR:  dec_op = ALU_OR;
                    `CORE_FN_XOR: dec_op = ALU_XOR;
                    `CORE_FN_NOR: dec_op = ALU_NOR;
                    `CORE_FN_SLT: dec_op = ALU_SLT;
                    `CORE_FN_SLL: dec_op = ALU_SLL;
                    `CORE_FN_SRL: dec_op = ALU_SRL;
                    default:      dec_known = 1'b0;
                endcase
            end
            `CORE_OP_ADDI: dec_op = ALU_ADD;
            `CORE_OP_SLTI: dec_op = ALU_SLT;
            `CORE_OP_ANDI: begin
                dec_op       = ALU_AND;
                dec_zero_ext = 1'b1;
            end
            `CORE_OP_ORI: begin
                dec_op       = ALU_OR;
                dec_zero_ext = 1'b1;
            end
            `CORE_OP_LUI:  dec_op = ALU_LUI;
            default:       dec_known = 1'b0;
        endcase
    end

    // Logic immediates are zero extended, the rest sign extended
    assign imm_ext = dec_zero_ext ? {{(`CORE_XLEN-16){1'b0}}, imm}
                                  : {{(`CORE_XLEN-16){imm[15]}}, imm};

    // ID/EX valid, dropped for unknown encodings and writes to $zero
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            id_ex.valid <= 1'b0;
        end else if (!imem_stall) begin
            id_ex.valid <= instr_valid && dec_known && (dec_dest != '0);
        end
    end

    // ID/EX payload
    always_ff @(posedge clk) begin
        if (!imem_stall) begin
            id_ex.alu_op      <= dec_op;
            id_ex.use_imm     <= dec_use_imm;
            id_ex.rs          <= rs_idx;
            id_ex.rt          <= rt_idx;
            id_ex.dest        <= dec_dest;
            id_ex.rs_data     <= rs_data;
            id_ex.rt_data     <= rt_data;
            id_ex.operand_imm <= imm_ext;
            id_ex.shamt       <= shamt;
        end
    end

    // Forwarding in execute relies on no valid entry targeting $zero
    no_valid_zero_dest: assert property (
        @(posedge clk) disable iff (!rst_n)
        id_ex.valid |-> (id_ex.dest != '0)
    );

endmodule

// File: hw/fetch_unit.sv
`include "core_params.svh"

module fetch_unit
    import core_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   imem_stall,
    input  word_t  imem_rdata,
    output iaddr_t imem_addr,
    output word_t  instr,
    output logic   instr_valid
);

    word_t pc;

    // PC and IF/ID valid, both frozen by a stalled fetch
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc          <= `CORE_RESET_PC;
            instr_valid <= 1'b0;
        end else if (!imem_stall) begin
            pc          <= pc + word_t'(4);
            instr_valid <= 1'b1;
        end
    end

    // IF/ID instruction word
    always_ff @(posedge clk) begin
        if (!imem_stall) begin
            instr <= imem_rdata;
        end
    end

    assign imem_addr = pc[`CORE_XLEN-1:2];

    // The instruction port must see a steady address while it stalls
    pc_hold_on_stall: assert property (
        @(posedge clk) disable iff (!rst_n)
        imem_stall |=> $stable(pc)
    );

endmodule

// File: hw/id_ex_if.sv
interface id_ex_if
    import core_pkg::*;
();

    logic     valid;
    alu_op_t  alu_op;
    logic     use_imm;
    reg_idx_t rs;
    reg_idx_t rt;
    reg_idx_t dest;
    word_t    rs_data;
    word_t    rt_data;
    // Immediate already extended to a full word
    word_t    operand_imm;
    shamt_t   shamt;

    modport decode (
        output valid, alu_op, use_imm, rs, rt, dest,
        output rs_data, rt_data, operand_imm, shamt
    );

    modport execute (
        input valid, alu_op, use_imm, rs, rt, dest,
        input rs_data, rt_data, operand_imm, shamt
    );

endinterface

// File: hw/core_pkg.sv
`include "core_params.svh"

package core_pkg;

    typedef logic [`CORE_XLEN-1:0]              word_t;
    typedef logic [`CORE_ADDR_W-1:0]            iaddr_t;
    typedef logic [$clog2(`CORE_REG_COUNT)-1:0] reg_idx_t;

    // Instruction fields
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;
    typedef logic [4:0]  shamt_t;
    typedef logic [15:0] imm_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_LUI
    } alu_op_t;

endpackage

// File: hw/core_params.svh
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// Datapath and register file sizes
`define CORE_XLEN       32
`define CORE_REG_COUNT  32
`define CORE_ADDR_W     30

// Byte address of the first fetch after reset
`define CORE_RESET_PC   32'h0000_0000

// Opcode field values
`define CORE_OP_RTYPE   6'h00
`define CORE_OP_ADDI    6'h08
`define CORE_OP_SLTI    6'h0a
`define CORE_OP_ANDI    6'h0c
`define CORE_OP_ORI     6'h0d
`define CORE_OP_LUI     6'h0f

// Funct field values for R-type
`define CORE_FN_SLL     6'h00
`define CORE_FN_SRL     6'h02
`define CORE_FN_ADD     6'h20
`define CORE_FN_SUB     6'h22
`define CORE_FN_AND     6'h24
`define CORE_FN_OR      6'h25
`define CORE_FN_XOR     6'h26
`define CORE_FN_NOR     6'h27
`define CORE_FN_SLT     6'h2a

`endif
